//--- testbench/token_engine_input.txt
// columns: weight_base ifmap_base opsum_base tile_n max_ack_delay exp_writes exp_pulses
// all values hex, one test case per line
0010 0100 1000 02 0 08 02
0020 0200 2000 06 3 18 06
0030 0300 3000 09 5 24 09
0040 0400 4000 01 2 04 01

//--- build.f
verilog/glb_bus_pkg.sv
verilog/engine_cfg_pkg.sv
verilog/pass_controller.sv
verilog/weight_loader.sv
verilog/ifmap_fetcher.sv
verilog/lane_fifo_bank.sv
verilog/pe_issue_ctrl.sv
verilog/token_arbiter.sv
verilog/token_engine.sv
testbench/tb_clock_gen.sv
testbench/token_engine_props.sv
testbench/tb_token_engine.sv

//--- testbench/tb_token_engine.sv
`timescale 1ns/1ns

module tb_token_engine import engine_cfg_pkg::*; import glb_bus_pkg::*; ();

    localparam int COLS       = 7;    // words per test line
    localparam int MAX_TESTS  = 8;
    localparam int WAIT_LIMIT = 5000; // cycles per wait

    logic              clk;
    logic              rst_n_i;
    logic              start_i;
    pass_cfg_t         cfg_i;
    logic              pass_done_o;
    logic              glb_req_o;
    glb_req_t          glb_rq_o;
    logic              glb_ack_i;
    logic [WORD_W-1:0] glb_rdata_i;
    logic              pe_valid_o;
    pe_tile_t          pe_tile_o;
    logic              pe_ret_valid_i;
    opsum_tile_t       opsum_i;

    logic [WORD_W-1:0] glb_mem [0:(1 << ADDR_W) - 1];
    logic [31:0]       test_words [0:COLS*MAX_TESTS-1];

    integer            seed = 44;
    int                num_tests;
    int                tests_run;
    int                checks;
    int                errors;
    int                write_cnt;
    int                pulse_cnt;
    int                max_delay;
    int                wait_left;
    bit                pending;
    logic [ADDR_W-1:0] cur_wbase;
    logic [ADDR_W-1:0] cur_ibase;
    logic [ADDR_W-1:0] cur_obase;

    logic        req_s;       // values sampled at the clock edge
    glb_req_t    rq_s;
    logic        pv_s;
    pe_tile_t    tile_s;
    logic        pv_d1 = 1'b0;
    opsum_tile_t sum_d1 = '0;

    tb_clock_gen #(.PERIOD_NS(20)) u_clock_gen (.clk_o(clk));

    token_engine u_token_engine (
        .clk(clk), .rst_n_i(rst_n_i), .start_i(start_i), .cfg_i(cfg_i),
        .pass_done_o(pass_done_o), .glb_req_o(glb_req_o), .glb_rq_o(glb_rq_o),
        .glb_ack_i(glb_ack_i), .glb_rdata_i(glb_rdata_i), .pe_valid_o(pe_valid_o),
        .pe_tile_o(pe_tile_o), .pe_ret_valid_i(pe_ret_valid_i), .opsum_i(opsum_i)
    );

    bind token_engine token_engine_props u_token_engine_props (
        .clk(clk), .rst_n_i(rst_n_i), .glb_req_i(glb_req_o), .glb_rq_i(glb_rq_o),
        .glb_ack_i(glb_ack_i), .pe_valid_i(pe_valid_o), .owner_i(u_token_arbiter.owner_q)
    );

    // power-on contents of GLB word a
    function automatic logic [WORD_W-1:0] init_word(input int addr);
        return WORD_W'(addr * 3 + 1);
    endfunction

    function automatic logic [WORD_W-1:0] expected_opsum(input int k);
        logic [WGT_W-1:0] w;
        w = WGT_W'(init_word(cur_wbase + k % NUM_LANES));
        return WORD_W'(init_word(cur_ibase + k) * w);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] t=%0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_tile(input pe_tile_t tile);
        int l;
        for (l = 0; l < NUM_LANES; l++) begin
            check_value($sformatf("pe_tile_o.data[%0d]", l), tile.data[l],
                        init_word(cur_ibase + pulse_cnt * NUM_LANES + l));
            check_value($sformatf("pe_tile_o.wgt[%0d]", l), tile.wgt[l],
                        init_word(cur_wbase + l) & 16'h00ff); // low byte only
        end
    endtask

    // GLB slave, four-phase with random ack delay
    always @(posedge clk) begin
        req_s = glb_req_o;
        rq_s  = glb_rq_o;
        #2;
        if (!glb_ack_i && req_s) begin
            if (!pending) begin
                wait_left = ($random(seed) & 32'h7fff_ffff) % (max_delay + 1);
                pending   = 1'b1;
            end
            if (wait_left == 0) begin
                pending   = 1'b0;
                glb_ack_i = 1'b1;
                if (rq_s.we) begin
                    check_value("glb_rq_o.addr", rq_s.addr, ADDR_W'(cur_obase + write_cnt));
                    check_value("glb_rq_o.wdata", rq_s.wdata, expected_opsum(write_cnt));
                    glb_mem[rq_s.addr] = rq_s.wdata;
                    write_cnt++;
                end else begin
                    glb_rdata_i = glb_mem[rq_s.addr];
                end
            end else begin
                wait_left--;
            end
        end else if (glb_ack_i && !req_s) begin
            glb_ack_i = 1'b0;
        end
    end

    // PE array, fixed two cycle latency
    always @(posedge clk) begin
        int l;
        pv_s   = pe_valid_o;
        tile_s = pe_tile_o;
        #2;
        pe_ret_valid_i = pv_d1;
        opsum_i        = sum_d1;
        pv_d1          = pv_s;
        for (l = 0; l < NUM_LANES; l++) begin
            sum_d1.sum[l] = DATA_W'(tile_s.data[l] * tile_s.wgt[l]);
        end
        if (pv_s) begin
            check_tile(tile_s);
            pulse_cnt++;
        end
    end

    task automatic wait_done_level(input logic level, output bit ok);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (pass_done_o !== level && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        ok = (pass_done_o === level);
    endtask

    task automatic run_pass(input int t, output bit ok);
        int base;
        int err_before;
        base       = t * COLS;
        err_before = errors;
        ok         = 1'b0;
        @(posedge clk);
        #2;
        cur_wbase         = test_words[base][ADDR_W-1:0];
        cur_ibase         = test_words[base+1][ADDR_W-1:0];
        cur_obase         = test_words[base+2][ADDR_W-1:0];
        max_delay         = test_words[base+4];
        write_cnt         = 0;
        pulse_cnt         = 0;
        cfg_i.weight_base = cur_wbase;
        cfg_i.ifmap_base  = cur_ibase;
        cfg_i.opsum_base  = cur_obase;
        cfg_i.tile_n      = test_words[base+3][TILE_W-1:0];
        start_i           = 1'b1;
        wait_done_level(1'b1, ok);
        if (!ok) begin
            $display("test %0d: pass_done_o did not rise within %0d cycles", t, WAIT_LIMIT);
            return;
        end
        check_value("glb write count", write_cnt, test_words[base+5]);
        check_value("pe_valid_o pulse count", pulse_cnt, test_words[base+6]);
        repeat (2) @(negedge clk);
        check_value("pass_done_o", pass_done_o, 1); // held while start_i is high
        @(posedge clk);
        #2;
        start_i = 1'b0;
        wait_done_level(1'b0, ok);
        if (!ok) begin
            $display("test %0d: pass_done_o did not fall after start_i dropped", t);
            return;
        end
        check_value("glb_req_o", glb_req_o, 0);
        $display("test %0d: tile_n=%0d max_delay=%0d writes=%0d pulses=%0d errors=%0d",
                 t, cfg_i.tile_n, max_delay, write_cnt, pulse_cnt, errors - err_before);
    endtask

    initial begin
        int  a;
        int  t;
        bit  ok;
        bit  timed_out;
        rst_n_i        = 1'b0;
        start_i        = 1'b0;
        cfg_i          = '0;
        glb_ack_i      = 1'b0;
        glb_rdata_i    = '0;
        pe_ret_valid_i = 1'b0;
        opsum_i        = '0;
        checks         = 0;
        errors         = 0;
        tests_run      = 0;
        write_cnt      = 0;
        pulse_cnt      = 0;
        max_delay      = 0;
        wait_left      = 0;
        pending        = 1'b0;
        timed_out      = 1'b0;
        cur_wbase      = '0;
        cur_ibase      = '0;
        cur_obase      = '0;
        for (a = 0; a < (1 << ADDR_W); a++) begin
            glb_mem[a] = init_word(a);
        end
        for (a = 0; a < COLS * MAX_TESTS; a++) begin
            test_words[a] = 32'hffff_ffff; // marks unused test slots
        end
        $readmemh("testbench/token_engine_input.txt", test_words);
        num_tests = 0;
        while (num_tests < MAX_TESTS && test_words[num_tests*COLS] !== 32'hffff_ffff) begin
            num_tests++;
        end
        if (num_tests == 0) begin
            $display("no test cases found in testbench/token_engine_input.txt");
        end

        repeat (16) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        @(negedge clk);
        check_value("glb_req_o", glb_req_o, 0);
        check_value("pe_valid_o", pe_valid_o, 0);
        check_value("pass_done_o", pass_done_o, 0);

        for (t = 0; t < num_tests && !timed_out; t++) begin
            run_pass(t, ok);
            tests_run++;
            if (!ok) timed_out = 1'b1;
        end

        // failures of the bound handshake assertions count as errors
        errors = errors + u_token_engine.u_token_engine_props.fail_cnt;
        $display("%0d of %0d tests run, %0d checks, %0d errors", tests_run, num_tests,
                 checks, errors);
        if (errors == 0 && !timed_out && num_tests > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- testbench/token_engine_props.sv
`timescale 1ns/1ns

module token_engine_props import glb_bus_pkg::*; (
    input logic       clk,
    input logic       rst_n_i,
    input logic       glb_req_i,
    input glb_req_t   glb_rq_i,
    input logic       glb_ack_i,
    input logic       pe_valid_i,
    input requester_e owner_i
);

    int fail_cnt = 0; // failed assertions so far

    req_held_until_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
        glb_req_i && !glb_ack_i |=> glb_req_i)
        else begin
            $error("glb_req_o fell before glb_ack_i was seen");
            fail_cnt++;
        end

    // request fields frozen once req is up
    rq_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        glb_req_i && $past(glb_req_i) |-> $stable(glb_rq_i))
        else begin
            $error("glb_rq_o changed while glb_req_o was high");
            fail_cnt++;
        end

    req_rise_ack_low: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(glb_req_i) |-> !glb_ack_i)
        else begin
            $error("glb_req_o rose while glb_ack_i was still high");
            fail_cnt++;
        end

    // an ack must always have someone to go to
    ack_has_owner: assert property (@(posedge clk) disable iff (!rst_n_i)
        glb_ack_i |-> owner_i != REQ_NONE)
        else begin
            $error("glb_ack_i high with no arbiter owner");
            fail_cnt++;
        end

    pe_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        pe_valid_i |=> !pe_valid_i)
        else begin
            $error("pe_valid_o high for more than one cycle");
            fail_cnt++;
        end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o; // free running
    end

endmodule

//--- verilog/token_engine.sv
`timescale 1ns/1ns

module token_engine import engine_cfg_pkg::*; import glb_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        start_i,
    input  pass_cfg_t   cfg_i,
    output logic        pass_done_o,
    output logic        glb_req_o,
    output glb_req_t    glb_rq_o,
    input  logic        glb_ack_i,
    input  logic [WORD_W-1:0] glb_rdata_i,
    output logic        pe_valid_o,
    output pe_tile_t    pe_tile_o,
    input  logic        pe_ret_valid_i,
    input  opsum_tile_t opsum_i
);

    pass_cfg_t     cfg;
    engine_phase_e phase;
    logic          weight_done, preheat_done, loop_done;
    logic          wgt_req, wgt_ack, ifm_req, ifm_ack, opsum_req, opsum_ack;
    glb_req_t      wgt_rq, ifm_rq, opsum_rq;

    logic [NUM_LANES-1:0][WGT_W-1:0]  weights;
    logic [NUM_LANES-1:0]             push, lane_full, lane_empty;
    logic [DATA_W-1:0]                push_data;
    logic                             pop;
    logic [NUM_LANES-1:0][DATA_W-1:0] pop_data;

    pass_controller u_pass_controller (
        .clk(clk), .rst_n_i(rst_n_i), .start_i(start_i),
        .weight_done_i(weight_done), .preheat_done_i(preheat_done), .loop_done_i(loop_done),
        .cfg_i(cfg_i), .cfg_o(cfg), .phase_o(phase), .pass_done_o(pass_done_o)
    );

    weight_loader u_weight_loader (
        .clk(clk), .rst_n_i(rst_n_i), .phase_i(phase), .weight_base_i(cfg.weight_base),
        .req_o(wgt_req), .rq_o(wgt_rq), .ack_i(wgt_ack), .rdata_i(glb_rdata_i),
        .weights_o(weights), .done_o(weight_done)
    );

    ifmap_fetcher u_ifmap_fetcher (
        .clk(clk), .rst_n_i(rst_n_i), .phase_i(phase), .cfg_i(cfg), .lane_full_i(lane_full),
        .req_o(ifm_req), .rq_o(ifm_rq), .ack_i(ifm_ack), .rdata_i(glb_rdata_i),
        .push_o(push), .push_data_o(push_data), .preheat_done_o(preheat_done)
    );

    // FIFOs are emptied between passes
    lane_fifo_bank u_lane_fifo_bank (
        .clk(clk), .rst_n_i(rst_n_i), .clear_i(pass_done_o),
        .push_i(push), .push_data_i(push_data), .pop_i(pop),
        .full_o(lane_full), .empty_o(lane_empty), .pop_data_o(pop_data)
    );

    pe_issue_ctrl u_pe_issue_ctrl (
        .clk(clk), .rst_n_i(rst_n_i), .phase_i(phase), .tile_n_i(cfg.tile_n),
        .opsum_base_i(cfg.opsum_base), .empty_i(lane_empty), .pop_data_i(pop_data),
        .weights_i(weights), .pop_o(pop), .pe_valid_o(pe_valid_o), .pe_tile_o(pe_tile_o),
        .pe_ret_valid_i(pe_ret_valid_i), .opsum_i(opsum_i),
        .req_o(opsum_req), .rq_o(opsum_rq), .ack_i(opsum_ack), .loop_done_o(loop_done)
    );

    token_arbiter u_token_arbiter (
        .clk(clk), .rst_n_i(rst_n_i),
        .wgt_req_i(wgt_req), .wgt_rq_i(wgt_rq),
        .opsum_req_i(opsum_req), .opsum_rq_i(opsum_rq),
        .ifm_req_i(ifm_req), .ifm_rq_i(ifm_rq),
        .wgt_ack_o(wgt_ack), .opsum_ack_o(opsum_ack), .ifm_ack_o(ifm_ack),
        .glb_req_o(glb_req_o), .glb_rq_o(glb_rq_o), .glb_ack_i(glb_ack_i)
    );

endmodule

//--- verilog/token_arbiter.sv
`timescale 1ns/1ns

module token_arbiter import glb_bus_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     wgt_req_i,
    input  glb_req_t wgt_rq_i,
    input  logic     opsum_req_i,
    input  glb_req_t opsum_rq_i,
    input  logic     ifm_req_i,
    input  glb_req_t ifm_rq_i,
    output logic     wgt_ack_o,
    output logic     opsum_ack_o,
    output logic     ifm_ack_o,
    output logic     glb_req_o,
    output glb_req_t glb_rq_o,
    input  logic     glb_ack_i
);

    requester_e owner_q;
    requester_e grant_d;
    logic       acked_q; // owner's ack already seen

    // fixed priority
    always_comb begin
        if (wgt_req_i) grant_d = REQ_WEIGHT;
        else if (opsum_req_i) grant_d = REQ_OPSUM;
        else if (ifm_req_i) grant_d = REQ_IFMAP;
        else grant_d = REQ_NONE;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            owner_q <= REQ_NONE;
            acked_q <= 1'b0;
        end else if (owner_q == REQ_NONE) begin
            if (!glb_ack_i) owner_q <= grant_d;
        end else if (acked_q && !glb_ack_i) begin
            owner_q <= REQ_NONE; // four-phase cycle finished
            acked_q <= 1'b0;
        end else if (glb_ack_i) begin
            acked_q <= 1'b1;
        end
    end

    always_comb begin
        case (owner_q)
            REQ_WEIGHT: begin
                glb_req_o = wgt_req_i;
                glb_rq_o  = wgt_rq_i;
            end
            REQ_OPSUM: begin
                glb_req_o = opsum_req_i;
                glb_rq_o  = opsum_rq_i;
            end
            REQ_IFMAP: begin
                glb_req_o = ifm_req_i;
                glb_rq_o  = ifm_rq_i;
            end
            default: begin
                glb_req_o = 1'b0;
                glb_rq_o  = '0;
            end
        endcase
    end

    assign wgt_ack_o   = (owner_q == REQ_WEIGHT) && glb_ack_i;
    assign opsum_ack_o = (owner_q == REQ_OPSUM) && glb_ack_i;
    assign ifm_ack_o   = (owner_q == REQ_IFMAP) && glb_ack_i;

endmodule

//--- verilog/pe_issue_ctrl.sv
`timescale 1ns/1ns

module pe_issue_ctrl import engine_cfg_pkg::*; import glb_bus_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  engine_phase_e                    phase_i,
    input  logic [TILE_W-1:0]                tile_n_i,
    input  logic [ADDR_W-1:0]                opsum_base_i,
    input  logic [NUM_LANES-1:0]             empty_i,
    input  logic [NUM_LANES-1:0][DATA_W-1:0] pop_data_i,
    input  logic [NUM_LANES-1:0][WGT_W-1:0]  weights_i,
    output logic                             pop_o,
    output logic                             pe_valid_o,
    output pe_tile_t                         pe_tile_o,
    input  logic                             pe_ret_valid_i,
    input  opsum_tile_t                      opsum_i,
    output logic                             req_o,
    output glb_req_t                         rq_o,
    input  logic                             ack_i,
    output logic                             loop_done_o
);

    typedef enum logic [1:0] {
        IS_ISSUE,  // wait for a full tile in the FIFOs
        IS_WAIT,   // PE array busy
        IS_WRITE   // opsum write-back, one lane per handshake
    } issue_st_e;

    issue_st_e         st_q;
    logic [TILE_W-1:0] tile_cnt_q;
    logic [LANE_W-1:0] lane_q;
    logic              req_q;
    logic              done_q;
    logic              issue;
    opsum_tile_t       opsum_q;

    assign issue = (phase_i == PH_NORMAL) && st_q == IS_ISSUE && ~|empty_i
                   && tile_cnt_q < tile_n_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            st_q       <= IS_ISSUE;
            tile_cnt_q <= '0;
            lane_q     <= '0;
            req_q      <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            if (phase_i == PH_IDLE) begin
                st_q       <= IS_ISSUE;
                tile_cnt_q <= '0;
            end else begin
                case (st_q)
                    IS_ISSUE: if (issue) st_q <= IS_WAIT;
                    IS_WAIT: begin
                        if (pe_ret_valid_i) begin
                            st_q   <= IS_WRITE;
                            lane_q <= '0;
                        end
                    end
                    IS_WRITE: begin
                        if (req_q && ack_i) begin
                            req_q  <= 1'b0;
                            lane_q <= lane_q + 1'b1;
                            if (lane_q == LANE_W'(NUM_LANES - 1)) begin
                                st_q       <= IS_ISSUE;
                                tile_cnt_q <= tile_cnt_q + 1'b1;
                            end
                        end else if (!req_q && !ack_i) begin
                            req_q <= 1'b1;
                        end
                    end
                    default: st_q <= IS_ISSUE;
                endcase
            end
            done_q <= (phase_i == PH_NORMAL) && st_q == IS_ISSUE && tile_cnt_q == tile_n_i
                      && !ack_i && !done_q;
        end
    end

    always_ff @(posedge clk) begin
        if (st_q == IS_WAIT && pe_ret_valid_i) begin
            opsum_q <= opsum_i;
        end
    end

    assign pop_o          = issue;
    assign pe_valid_o     = issue;
    assign pe_tile_o.data = pop_data_i; // FIFO heads
    assign pe_tile_o.wgt  = weights_i;

    assign req_o       = req_q;
    assign rq_o.addr   = opsum_base_i + ADDR_W'({tile_cnt_q, lane_q});
    assign rq_o.we     = 1'b1;
    assign rq_o.wdata  = opsum_q.sum[lane_q];
    assign loop_done_o = done_q;

endmodule

//--- verilog/lane_fifo_bank.sv
`timescale 1ns/1ns

module lane_fifo_bank import engine_cfg_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             clear_i,
    input  logic [NUM_LANES-1:0]             push_i,
    input  logic [DATA_W-1:0]                push_data_i,
    input  logic                             pop_i,       // pops every lane at once
    output logic [NUM_LANES-1:0]             full_o,
    output logic [NUM_LANES-1:0]             empty_o,
    output logic [NUM_LANES-1:0][DATA_W-1:0] pop_data_o
);

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        logic [DATA_W-1:0]     mem [FIFO_DEPTH];
        logic [FIFO_PTR_W-1:0] wr_ptr_q;
        logic [FIFO_PTR_W-1:0] rd_ptr_q;

        always_ff @(posedge clk or negedge rst_n_i) begin
            if (!rst_n_i) begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
            end else if (clear_i) begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
            end else begin
                if (push_i[l]) wr_ptr_q <= wr_ptr_q + 1'b1;
                if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (push_i[l]) begin
                mem[wr_ptr_q[FIFO_PTR_W-2:0]] <= push_data_i;
            end
        end

        // same index with opposite wrap bit means full
        assign full_o[l]     = (wr_ptr_q == {~rd_ptr_q[FIFO_PTR_W-1], rd_ptr_q[FIFO_PTR_W-2:0]});
        assign empty_o[l]    = (wr_ptr_q == rd_ptr_q);
        assign pop_data_o[l] = mem[rd_ptr_q[FIFO_PTR_W-2:0]];
    end

endmodule

//--- verilog/ifmap_fetcher.sv
`timescale 1ns/1ns

module ifmap_fetcher import engine_cfg_pkg::*; import glb_bus_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  engine_phase_e        phase_i,
    input  pass_cfg_t            cfg_i,
    input  logic [NUM_LANES-1:0] lane_full_i,
    output logic                 req_o,
    output glb_req_t             rq_o,
    input  logic                 ack_i,
    input  logic [WORD_W-1:0]    rdata_i,
    output logic [NUM_LANES-1:0] push_o,
    output logic [DATA_W-1:0]    push_data_o,
    output logic                 preheat_done_o
);

    // flat word index, tile in the upper bits and lane in the lower
    logic [TILE_W+LANE_W-1:0] idx_q;
    logic [TILE_W+LANE_W-1:0] limit;
    logic [TILE_W+LANE_W-1:0] pre_words;
    logic [TILE_W-1:0]        pre_tiles;
    logic [LANE_W-1:0]        lane;
    logic                     req_q;
    logic                     done_q;
    logic                     active;
    logic                     can_issue;

    assign lane      = idx_q[LANE_W-1:0];
    assign active    = (phase_i == PH_PREHEAT) || (phase_i == PH_NORMAL);
    assign pre_tiles = (cfg_i.tile_n < FIFO_DEPTH) ? cfg_i.tile_n : TILE_W'(FIFO_DEPTH);
    assign pre_words = {pre_tiles, {LANE_W{1'b0}}};
    assign limit     = (phase_i == PH_PREHEAT) ? pre_words : {cfg_i.tile_n, {LANE_W{1'b0}}};
    assign can_issue = active && !req_q && !ack_i && idx_q < limit && !lane_full_i[lane];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            idx_q  <= '0;
            req_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            if (phase_i == PH_IDLE) begin
                idx_q <= '0;
            end else if (req_q && ack_i) begin
                req_q <= 1'b0;
                idx_q <= idx_q + 1'b1;
            end else if (can_issue) begin
                req_q <= 1'b1;
            end
            done_q <= (phase_i == PH_PREHEAT) && idx_q == pre_words && !req_q && !ack_i
                      && !done_q;
        end
    end

    // the read word goes straight into its lane on the ack cycle
    always_comb begin
        push_o = '0;
        if (req_q && ack_i) begin
            push_o[lane] = 1'b1;
        end
    end

    assign push_data_o    = rdata_i;
    assign req_o          = req_q;
    assign rq_o.addr      = cfg_i.ifmap_base + ADDR_W'(idx_q);
    assign rq_o.we        = 1'b0;
    assign rq_o.wdata     = '0;
    assign preheat_done_o = done_q;

endmodule

//--- verilog/weight_loader.sv
`timescale 1ns/1ns

module weight_loader import engine_cfg_pkg::*; import glb_bus_pkg::*; (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  engine_phase_e                   phase_i,
    input  logic [ADDR_W-1:0]               weight_base_i,
    output logic                            req_o,
    output glb_req_t                        rq_o,
    input  logic                            ack_i,
    input  logic [WORD_W-1:0]               rdata_i,
    output logic [NUM_LANES-1:0][WGT_W-1:0] weights_o,
    output logic                            done_o
);

    logic [LANE_W:0]                 cnt_q;  // lanes loaded so far
    logic                            req_q;
    logic                            done_q;
    logic [NUM_LANES-1:0][WGT_W-1:0] weights_q;
    logic                            in_phase;

    assign in_phase = (phase_i == PH_WEIGHT);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q  <= '0;
            req_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            if (phase_i == PH_IDLE) begin
                cnt_q <= '0;
            end else if (in_phase && req_q && ack_i) begin
                req_q <= 1'b0;
                cnt_q <= cnt_q + 1'b1;
            end else if (in_phase && !req_q && !ack_i && cnt_q < NUM_LANES) begin
                req_q <= 1'b1;
            end
            // one cycle pulse once the last ack has fallen
            done_q <= in_phase && cnt_q == NUM_LANES && !req_q && !ack_i && !done_q;
        end
    end

    // weights stay put until the next weight phase
    always_ff @(posedge clk) begin
        if (in_phase && req_q && ack_i) begin
            weights_q[cnt_q[LANE_W-1:0]] <= rdata_i[WGT_W-1:0];
        end
    end

    assign req_o      = req_q;
    assign rq_o.addr  = weight_base_i + ADDR_W'(cnt_q);
    assign rq_o.we    = 1'b0;
    assign rq_o.wdata = '0;
    assign weights_o  = weights_q;
    assign done_o     = done_q;

endmodule

//--- verilog/pass_controller.sv
`timescale 1ns/1ns

module pass_controller import engine_cfg_pkg::*; (
    input  logic          clk,
    input  logic          rst_n_i,
    input  logic          start_i,
    input  logic          weight_done_i,
    input  logic          preheat_done_i,
    input  logic          loop_done_i,
    input  pass_cfg_t     cfg_i,
    output pass_cfg_t     cfg_o,
    output engine_phase_e phase_o,
    output logic          pass_done_o
);

    engine_phase_e state_q;
    engine_phase_e state_d;
    pass_cfg_t     cfg_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            PH_IDLE:    if (start_i) state_d = PH_WEIGHT;
            PH_WEIGHT:  if (weight_done_i) state_d = PH_PREHEAT;
            PH_PREHEAT: if (preheat_done_i) state_d = PH_NORMAL;
            PH_NORMAL:  if (loop_done_i) state_d = PH_DONE;
            PH_DONE:    if (!start_i) state_d = PH_IDLE; // wait for start to drop
            default:    state_d = PH_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= PH_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // config is sampled once per pass
    always_ff @(posedge clk) begin
        if (state_q == PH_IDLE && start_i) begin
            cfg_q <= cfg_i;
        end
    end

    assign cfg_o       = cfg_q;
    assign phase_o     = state_q;
    assign pass_done_o = (state_q == PH_DONE);

endmodule

//--- verilog/engine_cfg_pkg.sv
package engine_cfg_pkg;

    localparam int NUM_LANES  = 4;
    localparam int LANE_W     = $clog2(NUM_LANES);
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH) + 1; // extra wrap bit
    localparam int DATA_W     = 16; // ifmap and opsum
    localparam int WGT_W      = 8;
    localparam int TILE_W     = 8;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_WEIGHT,
        PH_PREHEAT,
        PH_NORMAL,
        PH_DONE
    } engine_phase_e;

    typedef struct packed {
        logic [glb_bus_pkg::ADDR_W-1:0] weight_base;
        logic [glb_bus_pkg::ADDR_W-1:0] ifmap_base;
        logic [glb_bus_pkg::ADDR_W-1:0] opsum_base;
        logic [TILE_W-1:0]              tile_n;     // tiles in this pass
    } pass_cfg_t;

    typedef struct packed {
        logic [NUM_LANES-1:0][DATA_W-1:0] data;
        logic [NUM_LANES-1:0][WGT_W-1:0]  wgt;
    } pe_tile_t;

    typedef struct packed {
        logic [NUM_LANES-1:0][DATA_W-1:0] sum;
    } opsum_tile_t;

endpackage

//--- verilog/glb_bus_pkg.sv
package glb_bus_pkg;

    localparam int ADDR_W = 16; // word address
    localparam int WORD_W = 16;

    // one request on the GLB port
    // held stable for the whole four-phase cycle
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              we;    // 1 = write, 0 = read
        logic [WORD_W-1:0] wdata;
    } glb_req_t;

    // current owner of the shared GLB port
    typedef enum logic [1:0] {
        REQ_NONE,
        REQ_WEIGHT,
        REQ_OPSUM,
        REQ_IFMAP
    } requester_e;

endpackage
